// ==== common/turfio_bus_pkg.sv ====
package turfio_bus_pkg;

    // byte-addressed wishbone target port
    typedef logic [11:0] wb_adr_t;
    typedef logic [31:0] wb_dat_t;

    // byte address inside one 64-byte slot
    typedef logic [5:0] slot_adr_t;

    // address map
    // bit 11 picks the register core, bits 8:6 pick a SURF slot
    localparam int SLOT_SEL_LSB = 6;
    localparam int SLOT_SEL_W   = 3;
    localparam int REGS_SEL_BIT = 11;

    // register core offsets
    localparam slot_adr_t REG_CONTROL = 6'h00;
    localparam slot_adr_t REG_DISABLE = 6'h04;
    localparam slot_adr_t REG_RUNCMD  = 6'h08;
    localparam slot_adr_t REG_TRIG    = 6'h0C;
    localparam slot_adr_t REG_FW      = 6'h10;
    localparam slot_adr_t REG_STATUS  = 6'h14;

    // per-SURF slot offsets
    localparam slot_adr_t SREG_EVENTS  = 6'h00;
    localparam slot_adr_t SREG_DROPPED = 6'h04;
    localparam slot_adr_t SREG_FRAMES  = 6'h08;

endpackage

// ==== common/turfio_cmd_pkg.sv ====
package turfio_cmd_pkg;

    typedef logic [31:0] cmd_word_t;
    typedef logic [1:0]  runcmd_t;
    typedef logic [14:0] trig_adr_t;
    typedef logic [7:0]  fw_byte_t;
    typedef logic [1:0]  fw_mark_t;

    localparam runcmd_t RUN_IDLE  = 2'd0;
    localparam runcmd_t RUN_START = 2'd1;
    localparam runcmd_t RUN_STOP  = 2'd2;
    localparam runcmd_t RUN_RESET = 2'd3;

    // command word layout
    // bits 31:29 are reserved and pass through
    localparam int CMD_RUNCMD_LSB     = 0;
    localparam int CMD_TRIG_VALID_BIT = 2;
    localparam int CMD_TRIG_ADR_LSB   = 3;
    localparam int CMD_FW_VALID_BIT   = 18;
    localparam int CMD_FW_BYTE_LSB    = 19;
    localparam int CMD_FW_MARK_LSB    = 27;

    // readout side
    localparam int NUM_SURF = 7;
    typedef logic [NUM_SURF-1:0] surf_vec_t;

    typedef logic [15:0] event_num_t;

    // event high, event low, trigger address high, trigger address low
    localparam int FRAME_BYTES = 4;

endpackage

// ==== common/wb_if.sv ====
interface wb_if;
    import turfio_bus_pkg::*;

    logic    cyc;
    logic    stb;
    logic    we;
    wb_adr_t adr;
    wb_dat_t dat_w;
    wb_dat_t dat_r;
    logic    ack;

    // ack is a single-cycle pulse one cycle after cyc and stb
    modport master (
        output cyc, stb, we, adr, dat_w,
        input  dat_r, ack
    );

    modport target (
        input  cyc, stb, we, adr, dat_w,
        output dat_r, ack
    );

endinterface

// ==== hdl/wb_fanout.sv ====
module wb_fanout (
    input  logic                    sysclk_i,
    input  logic                    rst_i,
    input  logic                    wb_cyc_i,
    input  logic                    wb_stb_i,
    input  logic                    wb_we_i,
    input  turfio_bus_pkg::wb_adr_t wb_adr_i,
    input  turfio_bus_pkg::wb_dat_t wb_dat_i,
    output turfio_bus_pkg::wb_dat_t wb_dat_o,
    output logic                    wb_ack_o,
    wb_if.master                    regs_o,
    wb_if.master                    surf_o [turfio_cmd_pkg::NUM_SURF]
);
    import turfio_bus_pkg::*;
    import turfio_cmd_pkg::*;

    logic                  regs_sel;
    logic [SLOT_SEL_W-1:0] slot;
    logic                  empty_sel;
    logic                  empty_ack;
    wb_dat_t               surf_dat [NUM_SURF];
    surf_vec_t             surf_ack;

    // request is held until ack, so the live address also selects the return path
    assign regs_sel  = wb_adr_i[REGS_SEL_BIT];
    assign slot      = wb_adr_i[SLOT_SEL_LSB +: SLOT_SEL_W];
    assign empty_sel = !regs_sel && (slot >= NUM_SURF);

    assign regs_o.cyc   = wb_cyc_i;
    assign regs_o.stb   = wb_stb_i && regs_sel;
    assign regs_o.we    = wb_we_i;
    assign regs_o.adr   = wb_adr_i;
    assign regs_o.dat_w = wb_dat_i;

    for (genvar i = 0; i < NUM_SURF; i++) begin : g_slot
        assign surf_o[i].cyc   = wb_cyc_i;
        assign surf_o[i].stb   = wb_stb_i && !regs_sel && (slot == i);
        assign surf_o[i].we    = wb_we_i;
        assign surf_o[i].adr   = wb_adr_i;
        assign surf_o[i].dat_w = wb_dat_i;
        assign surf_dat[i]     = surf_o[i].dat_r;
        assign surf_ack[i]     = surf_o[i].ack;
    end

    // unpopulated slot answers on its own
    always_ff @(posedge sysclk_i) begin
        if (rst_i) begin
            empty_ack <= 1'b0;
        end else begin
            empty_ack <= wb_cyc_i && wb_stb_i && empty_sel && !empty_ack;
        end
    end

    always_comb begin
        if (regs_sel) begin
            wb_ack_o = regs_o.ack;
            wb_dat_o = regs_o.dat_r;
        end else if (empty_sel) begin
            wb_ack_o = empty_ack;
            wb_dat_o = '0;
        end else begin
            wb_ack_o = surf_ack[slot];
            wb_dat_o = surf_dat[slot];
        end
    end

    // whichever target answers, ack follows a request by one cycle
    a_ack_follows_req: assert property (@(posedge sysclk_i) disable iff (rst_i)
        wb_ack_o |-> $past(wb_cyc_i && wb_stb_i));

endmodule

// ==== hdl/surfturf_regs.sv ====
module surfturf_regs (
    input  logic                       sysclk_i,
    input  logic                       rst_i,
    wb_if.target                       wb,
    output logic                       event_reset_o,
    output turfio_cmd_pkg::surf_vec_t  disable_o,
    output turfio_cmd_pkg::runcmd_t    runcmd_o,
    output logic                       runcmd_valid_o,
    input  logic                       runcmd_ready_i,
    output turfio_cmd_pkg::trig_adr_t  trig_o,
    output logic                       trig_valid_o,
    input  logic                       trig_ready_i,
    output turfio_cmd_pkg::fw_byte_t   fw_o,
    output turfio_cmd_pkg::fw_mark_t   fw_mark_o,
    output logic                       fw_valid_o,
    input  logic                       fw_ready_i,
    input  logic                       fw_marked_i
);
    import turfio_bus_pkg::*;
    import turfio_cmd_pkg::*;

    logic       req;
    logic       wr_en;
    slot_adr_t  reg_adr;
    logic       load_runcmd;
    logic       load_trig;
    logic       load_fw;
    logic [2:0] pending;
    logic [2:0] ready;
    logic [7:0] marked_count;

    assign req     = wb.cyc && wb.stb && !wb.ack;
    assign wr_en   = req && wb.we;
    assign reg_adr = wb.adr[SLOT_SEL_LSB-1:0];

    // a write to a stream that is still pending is dropped
    assign load_runcmd = wr_en && (reg_adr == REG_RUNCMD) && !runcmd_valid_o;
    assign load_trig   = wr_en && (reg_adr == REG_TRIG) && !trig_valid_o;
    assign load_fw     = wr_en && (reg_adr == REG_FW) && !fw_valid_o;

    // same order as the status bits
    assign pending = {runcmd_valid_o, trig_valid_o, fw_valid_o};
    assign ready   = {runcmd_ready_i, trig_ready_i, fw_ready_i};

    always_ff @(posedge sysclk_i) begin
        if (rst_i) begin
            wb.ack         <= 1'b0;
            event_reset_o  <= 1'b0;
            disable_o      <= '0;
            runcmd_valid_o <= 1'b0;
            trig_valid_o   <= 1'b0;
            fw_valid_o     <= 1'b0;
            marked_count   <= '0;
        end else begin
            wb.ack        <= req;
            event_reset_o <= wr_en && (reg_adr == REG_CONTROL) && wb.dat_w[0];
            if (wr_en && (reg_adr == REG_DISABLE)) begin
                disable_o <= wb.dat_w[NUM_SURF-1:0];
            end
            if (runcmd_valid_o && runcmd_ready_i) begin
                runcmd_valid_o <= 1'b0;
            end else if (load_runcmd) begin
                runcmd_valid_o <= 1'b1;
            end
            if (trig_valid_o && trig_ready_i) begin
                trig_valid_o <= 1'b0;
            end else if (load_trig) begin
                trig_valid_o <= 1'b1;
            end
            if (fw_valid_o && fw_ready_i) begin
                fw_valid_o <= 1'b0;
            end else if (load_fw) begin
                fw_valid_o <= 1'b1;
            end
            if (fw_marked_i) begin
                marked_count <= marked_count + 1'b1;
            end
        end
    end

    // stream payloads and read data
    always_ff @(posedge sysclk_i) begin
        if (load_runcmd) begin
            runcmd_o <= wb.dat_w[$bits(runcmd_t)-1:0];
        end
        if (load_trig) begin
            trig_o <= wb.dat_w[$bits(trig_adr_t)-1:0];
        end
        if (load_fw) begin
            fw_o      <= wb.dat_w[7:0];
            fw_mark_o <= wb.dat_w[9:8];
        end
        case (reg_adr)
            REG_DISABLE: wb.dat_r <= wb_dat_t'(disable_o);
            REG_STATUS:  wb.dat_r <= {16'd0, marked_count, 5'd0, pending};
            default:     wb.dat_r <= '0;
        endcase
    end

    // once raised, a stream valid only drops through a transfer
    a_valid_held: assert property (@(posedge sysclk_i) disable iff (rst_i)
        ($past(pending) & ~pending & ~$past(ready)) == 3'b000);

endmodule

// ==== cmd_splice/turfio_cmd_splice.sv ====
module turfio_cmd_splice (
    input  logic                      sysclk_i,
    input  logic                      rst_i,
    input  turfio_cmd_pkg::cmd_word_t command_i,
    input  logic                      command_valid_i,
    input  logic                      command_locked_i,
    input  turfio_cmd_pkg::runcmd_t   runcmd_i,
    input  logic                      runcmd_valid_i,
    output logic                      runcmd_ready_o,
    input  turfio_cmd_pkg::trig_adr_t trig_i,
    input  logic                      trig_valid_i,
    output logic                      trig_ready_o,
    input  turfio_cmd_pkg::fw_byte_t  fw_i,
    input  turfio_cmd_pkg::fw_mark_t  fw_mark_i,
    input  logic                      fw_valid_i,
    output logic                      fw_ready_o,
    output logic                      fw_marked_o,
    output turfio_cmd_pkg::cmd_word_t spliced_o,
    output logic                      spliced_valid_o
);
    import turfio_cmd_pkg::*;

    logic      accept;
    cmd_word_t merged;

    // every queued stream moves only with a live command word
    assign accept         = command_valid_i && command_locked_i;
    assign runcmd_ready_o = accept;
    assign trig_ready_o   = accept;
    assign fw_ready_o     = accept;

    always_comb begin
        merged = command_i;
        if (runcmd_valid_i) begin
            merged[CMD_RUNCMD_LSB +: $bits(runcmd_t)] = runcmd_i;
        end
        if (trig_valid_i) begin
            merged[CMD_TRIG_VALID_BIT]                    = 1'b1;
            merged[CMD_TRIG_ADR_LSB +: $bits(trig_adr_t)] = trig_i;
        end
        if (fw_valid_i) begin
            merged[CMD_FW_VALID_BIT]                    = 1'b1;
            merged[CMD_FW_BYTE_LSB +: $bits(fw_byte_t)] = fw_i;
            merged[CMD_FW_MARK_LSB +: $bits(fw_mark_t)] = fw_mark_i;
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (rst_i) begin
            spliced_valid_o <= 1'b0;
            fw_marked_o     <= 1'b0;
        end else begin
            spliced_valid_o <= accept;
            fw_marked_o     <= accept && fw_valid_i && (fw_mark_i != '0);
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (accept) begin
            spliced_o <= merged;
        end
    end

    // no output word without an input word the cycle before
    a_valid_from_cmd: assert property (@(posedge sysclk_i) disable iff (rst_i)
        spliced_valid_o |-> $past(command_valid_i));

endmodule

// ==== surf/surf_channel.sv ====
module surf_channel (
    input  logic                      sysclk_i,
    input  logic                      rst_i,
    wb_if.target                      wb,
    input  turfio_cmd_pkg::cmd_word_t spliced_i,
    input  logic                      spliced_valid_i,
    input  logic                      event_reset_i,
    input  logic                      disable_i,
    output logic [7:0]                m_tdata_o,
    output logic                      m_tvalid_o,
    output logic                      m_tlast_o,
    input  logic                      m_tready_i
);
    import turfio_bus_pkg::*;
    import turfio_cmd_pkg::*;

    typedef enum logic {IDLE, SEND} send_state_t;

    send_state_t                      state;
    logic [$clog2(FRAME_BYTES)-1:0]   byte_idx;
    logic [7:0]                       frame [FRAME_BYTES];
    logic                             running;
    event_num_t                       event_num;
    event_num_t                       dropped;
    event_num_t                       frames;
    runcmd_t                          runcmd;
    trig_adr_t                        trig_adr;
    logic                             take_trig;
    logic                             load;
    logic                             drop;
    logic                             clear;
    logic                             xfer;
    slot_adr_t                        reg_adr;

    assign runcmd   = spliced_i[CMD_RUNCMD_LSB +: $bits(runcmd_t)];
    assign trig_adr = spliced_i[CMD_TRIG_ADR_LSB +: $bits(trig_adr_t)];

    // numbering advances even when disabled so channels stay aligned
    assign take_trig = spliced_valid_i && spliced_i[CMD_TRIG_VALID_BIT] && running;
    assign load      = take_trig && !disable_i && (state == IDLE);
    assign drop      = take_trig && !disable_i && (state == SEND);
    assign clear     = event_reset_i || (spliced_valid_i && (runcmd == RUN_RESET));

    assign m_tvalid_o = (state == SEND);
    assign m_tlast_o  = m_tvalid_o && (byte_idx == FRAME_BYTES - 1);
    assign m_tdata_o  = frame[byte_idx];
    assign xfer       = m_tvalid_o && m_tready_i;
    assign reg_adr    = wb.adr[SLOT_SEL_LSB-1:0];

    always_ff @(posedge sysclk_i) begin
        if (rst_i) begin
            state     <= IDLE;
            byte_idx  <= '0;
            running   <= 1'b0;
            event_num <= '0;
            dropped   <= '0;
            frames    <= '0;
            wb.ack    <= 1'b0;
        end else begin
            wb.ack <= wb.cyc && wb.stb && !wb.ack;
            if (spliced_valid_i && (runcmd == RUN_START)) begin
                running <= 1'b1;
            end else if (spliced_valid_i && (runcmd == RUN_STOP)) begin
                running <= 1'b0;
            end
            if (clear) begin
                event_num <= '0;
                dropped   <= '0;
                frames    <= '0;
            end else begin
                if (take_trig) event_num <= event_num + 1'b1;
                if (drop) dropped <= dropped + 1'b1;
                if (xfer && m_tlast_o) frames <= frames + 1'b1;
            end
            case (state)
                IDLE: begin
                    if (load) begin
                        state    <= SEND;
                        byte_idx <= '0;
                    end
                end
                SEND: begin
                    if (xfer) begin
                        byte_idx <= byte_idx + 1'b1;
                        if (m_tlast_o) state <= IDLE;
                    end
                end
            endcase
        end
    end

    // frame buffer and counter readback
    always_ff @(posedge sysclk_i) begin
        if (load) begin
            frame[0] <= event_num[15:8];
            frame[1] <= event_num[7:0];
            frame[2] <= {1'b0, trig_adr[14:8]};
            frame[3] <= trig_adr[7:0];
        end
        case (reg_adr)
            SREG_EVENTS:  wb.dat_r <= wb_dat_t'(event_num);
            SREG_DROPPED: wb.dat_r <= wb_dat_t'(dropped);
            SREG_FRAMES:  wb.dat_r <= wb_dat_t'(frames);
            default:      wb.dat_r <= '0;
        endcase
    end

endmodule

// ==== hdl/surfturf_top.sv ====
module surfturf_top (
    input  logic                                sysclk_i,
    input  logic                                rst_i,
    input  logic                                wb_cyc_i,
    input  logic                                wb_stb_i,
    input  logic                                wb_we_i,
    input  turfio_bus_pkg::wb_adr_t             wb_adr_i,
    input  turfio_bus_pkg::wb_dat_t             wb_dat_i,
    output turfio_bus_pkg::wb_dat_t             wb_dat_o,
    output logic                                wb_ack_o,
    input  turfio_cmd_pkg::cmd_word_t           command_i,
    input  logic                                command_valid_i,
    input  logic                                command_locked_i,
    output turfio_cmd_pkg::cmd_word_t           spliced_o,
    output logic                                spliced_valid_o,
    output logic [turfio_cmd_pkg::NUM_SURF-1:0][7:0] m_tdata_o,
    output turfio_cmd_pkg::surf_vec_t           m_tvalid_o,
    output turfio_cmd_pkg::surf_vec_t           m_tlast_o,
    input  turfio_cmd_pkg::surf_vec_t           m_tready_i
);
    import turfio_cmd_pkg::*;

    wb_if regs_bus ();
    wb_if surf_bus [NUM_SURF] ();

    logic      event_reset;
    surf_vec_t disable_mask;
    runcmd_t   runcmd;
    logic      runcmd_valid;
    logic      runcmd_ready;
    trig_adr_t trig;
    logic      trig_valid;
    logic      trig_ready;
    fw_byte_t  fw;
    fw_mark_t  fw_mark;
    logic      fw_valid;
    logic      fw_ready;
    logic      fw_marked;

    wb_fanout u_fanout (
        .sysclk_i (sysclk_i),
        .rst_i    (rst_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o),
        .regs_o   (regs_bus),
        .surf_o   (surf_bus)
    );

    surfturf_regs u_regs (
        .sysclk_i       (sysclk_i),
        .rst_i          (rst_i),
        .wb             (regs_bus),
        .event_reset_o  (event_reset),
        .disable_o      (disable_mask),
        .runcmd_o       (runcmd),
        .runcmd_valid_o (runcmd_valid),
        .runcmd_ready_i (runcmd_ready),
        .trig_o         (trig),
        .trig_valid_o   (trig_valid),
        .trig_ready_i   (trig_ready),
        .fw_o           (fw),
        .fw_mark_o      (fw_mark),
        .fw_valid_o     (fw_valid),
        .fw_ready_i     (fw_ready),
        .fw_marked_i    (fw_marked)
    );

    turfio_cmd_splice u_splice (
        .sysclk_i         (sysclk_i),
        .rst_i            (rst_i),
        .command_i        (command_i),
        .command_valid_i  (command_valid_i),
        .command_locked_i (command_locked_i),
        .runcmd_i         (runcmd),
        .runcmd_valid_i   (runcmd_valid),
        .runcmd_ready_o   (runcmd_ready),
        .trig_i           (trig),
        .trig_valid_i     (trig_valid),
        .trig_ready_o     (trig_ready),
        .fw_i             (fw),
        .fw_mark_i        (fw_mark),
        .fw_valid_i       (fw_valid),
        .fw_ready_o       (fw_ready),
        .fw_marked_o      (fw_marked),
        .spliced_o        (spliced_o),
        .spliced_valid_o  (spliced_valid_o)
    );

    // every channel sees the same spliced word
    for (genvar i = 0; i < NUM_SURF; i++) begin : g_surf
        surf_channel u_surf (
            .sysclk_i        (sysclk_i),
            .rst_i           (rst_i),
            .wb              (surf_bus[i]),
            .spliced_i       (spliced_o),
            .spliced_valid_i (spliced_valid_o),
            .event_reset_i   (event_reset),
            .disable_i       (disable_mask[i]),
            .m_tdata_o       (m_tdata_o[i]),
            .m_tvalid_o      (m_tvalid_o[i]),
            .m_tlast_o       (m_tlast_o[i]),
            .m_tready_i      (m_tready_i[i])
        );
    end

endmodule

// ==== verif/surfturf_checker.sv ====
module surfturf_checker (
    input  logic                                     sysclk_i,
    input  logic                                     rst_i,
    input  logic                                     wb_we_i,
    input  turfio_bus_pkg::wb_adr_t                  wb_adr_i,
    input  turfio_bus_pkg::wb_dat_t                  wb_dat_i,
    input  turfio_bus_pkg::wb_dat_t                  wb_dat_o_i,
    input  logic                                     wb_ack_i,
    input  turfio_cmd_pkg::cmd_word_t                spliced_i,
    input  logic                                     spliced_valid_i,
    input  logic [turfio_cmd_pkg::NUM_SURF-1:0][7:0] m_tdata_i,
    input  turfio_cmd_pkg::surf_vec_t                m_tvalid_i,
    input  turfio_cmd_pkg::surf_vec_t                m_tlast_i,
    input  turfio_cmd_pkg::surf_vec_t                m_tready_i
);
    import turfio_bus_pkg::*;
    import turfio_cmd_pkg::*;

    string      cur_name;
    int         test_errs;
    int         errors;
    int         tests;
    int         passed;
    logic       rd_armed;
    logic       sp_armed;
    wb_dat_t    rd_exp;
    cmd_word_t  sp_exp;
    // model of the run state shared by all channels
    logic       running;
    event_num_t ev;
    surf_vec_t  dis;
    surf_vec_t  busy;
    logic [31:0] frame [NUM_SURF];
    int         idx [NUM_SURF];

    task automatic begin_test(input string name);
        cur_name  = name;
        test_errs = 0;
    endtask

    task automatic expect_read(input wb_dat_t value);
        rd_exp   = value;
        rd_armed = 1'b1;
    endtask

    task automatic expect_splice(input cmd_word_t value);
        sp_exp   = value;
        sp_armed = 1'b1;
    endtask

    task automatic fail_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        $display("[FAIL] %s %s expected %h actual %h", cur_name, what, exp, act);
        test_errs++;
        errors++;
    endtask

    task automatic fail_text(input string msg);
        $display("error in %s: %s", cur_name, msg);
        test_errs++;
        errors++;
    endtask

    task automatic end_test();
        tests++;
        if (test_errs == 0) begin
            passed++;
            $display("[PASS] %s", cur_name);
        end else begin
            $display("test %s failed with %0d errors", cur_name, test_errs);
        end
    endtask

    task automatic summary();
        for (int i = 0; i < NUM_SURF; i++) begin
            if (busy[i]) begin
                fail_text($sformatf("channel %0d never finished its frame", i));
            end
        end
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 tests, passed, tests - passed, errors);
    endtask

    initial begin
        errors   = 0;
        tests    = 0;
        passed   = 0;
        rd_armed = 1'b0;
        sp_armed = 1'b0;
        cur_name = "reset";
    end

    always @(posedge sysclk_i) begin : model
        surf_vec_t busy_old;
        runcmd_t   rc;
        trig_adr_t adr;
        if (rst_i) begin
            running = 1'b0;
            ev      = '0;
            dis     = '0;
            busy    = '0;
        end else begin
            busy_old = busy;
            if (wb_ack_i && rd_armed && !wb_we_i) begin
                if (wb_dat_o_i !== rd_exp) fail_value("read", rd_exp, wb_dat_o_i);
                rd_armed = 1'b0;
            end
            if (wb_ack_i && wb_we_i && wb_adr_i[REGS_SEL_BIT]) begin
                if (wb_adr_i[5:0] == REG_DISABLE) dis = wb_dat_i[NUM_SURF-1:0];
                if (wb_adr_i[5:0] == REG_CONTROL && wb_dat_i[0]) ev = '0;
            end
            if (spliced_valid_i) begin
                if (!sp_armed) begin
                    fail_text("spliced word seen without a locked command");
                end else if (spliced_i !== sp_exp) begin
                    fail_value("spliced", sp_exp, spliced_i);
                end
                sp_armed = 1'b0;
                rc  = spliced_i[1:0];
                adr = spliced_i[17:3];
                // trigger sees the run state from before this word
                if (spliced_i[2] && running) begin
                    for (int i = 0; i < NUM_SURF; i++) begin
                        if (!dis[i] && !busy[i]) begin
                            frame[i] = {ev, 1'b0, adr[14:8], adr[7:0]};
                            busy[i]  = 1'b1;
                            idx[i]   = 0;
                        end
                    end
                    ev++;
                end
                if (rc == RUN_START) running = 1'b1;
                else if (rc == RUN_STOP) running = 1'b0;
                else if (rc == RUN_RESET) ev = '0;
            end
            for (int i = 0; i < NUM_SURF; i++) begin
                if (m_tvalid_i[i] && !busy_old[i]) begin
                    fail_text($sformatf("channel %0d sent a byte with no frame due", i));
                end else if (m_tvalid_i[i] && m_tready_i[i]) begin
                    if (m_tdata_i[i] !== frame[i][31-8*idx[i] -: 8]) begin
                        fail_value($sformatf("ch%0d byte%0d", i, idx[i]),
                                   frame[i][31-8*idx[i] -: 8], m_tdata_i[i]);
                    end
                    if (m_tlast_i[i] !== (idx[i] == FRAME_BYTES - 1)) begin
                        fail_value($sformatf("ch%0d tlast", i), idx[i] == FRAME_BYTES - 1,
                                   m_tlast_i[i]);
                    end
                    idx[i]++;
                    if (idx[i] == FRAME_BYTES) busy[i] = 1'b0;
                end
            end
        end
    end

endmodule

// ==== verif/tb_surfturf.sv ====
module tb_surfturf;
    import turfio_bus_pkg::*;
    import turfio_cmd_pkg::*;

    localparam int OP_WR    = 0;
    localparam int OP_RD    = 1;
    localparam int OP_CMD   = 2;
    localparam int OP_STALL = 3;
    localparam int MAX_TESTS = 64;
    localparam int CYCLES_PER_TEST = 30;

    logic sysclk_i;
    logic rst_i;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    logic wb_ack;
    wb_adr_t wb_adr;
    wb_dat_t wb_dat_w;
    wb_dat_t wb_dat_r;
    cmd_word_t command;
    cmd_word_t spliced;
    logic command_valid;
    logic command_locked;
    logic spliced_valid;
    logic [NUM_SURF-1:0][7:0] tdata;
    surf_vec_t tvalid;
    surf_vec_t tlast;
    surf_vec_t tready;
    surf_vec_t hold;
    logic [15:0] lfsr;
    int cycles;
    int limit;

    // table columns are name, op, address or lock flag or hold mask, data or word or cycles, expected
    string       t_name [MAX_TESTS];
    int          t_op [MAX_TESTS];
    logic [31:0] t_adr [MAX_TESTS];
    logic [31:0] t_dat [MAX_TESTS];
    logic [31:0] t_exp [MAX_TESTS];
    int          n_tests;

    surfturf_top DUT (
        .sysclk_i(sysclk_i), .rst_i(rst_i),
        .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we), .wb_adr_i(wb_adr),
        .wb_dat_i(wb_dat_w), .wb_dat_o(wb_dat_r), .wb_ack_o(wb_ack),
        .command_i(command), .command_valid_i(command_valid),
        .command_locked_i(command_locked), .spliced_o(spliced),
        .spliced_valid_o(spliced_valid), .m_tdata_o(tdata), .m_tvalid_o(tvalid),
        .m_tlast_o(tlast), .m_tready_i(tready)
    );

    surfturf_checker chk (
        .sysclk_i(sysclk_i), .rst_i(rst_i), .wb_we_i(wb_we), .wb_adr_i(wb_adr),
        .wb_dat_i(wb_dat_w), .wb_dat_o_i(wb_dat_r), .wb_ack_i(wb_ack),
        .spliced_i(spliced), .spliced_valid_i(spliced_valid), .m_tdata_i(tdata),
        .m_tvalid_i(tvalid), .m_tlast_i(tlast), .m_tready_i(tready)
    );

    always #20 sysclk_i = ~sysclk_i;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // random back-pressure with ready high about three cycles in four unless held
    always @(posedge sysclk_i) begin : ready_gen
        logic b1;
        logic b2;
        for (int i = 0; i < NUM_SURF; i++) begin
            b1 = lfsr[15];
            lfsr = lfsr_next(lfsr);
            b2 = lfsr[15];
            lfsr = lfsr_next(lfsr);
            tready[i] <= (b1 | b2) & !hold[i];
        end
    end

    always @(posedge sysclk_i) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("timeout: run stopped after %0d cycles without finishing", cycles);
            $display("Errors found");
            $finish;
        end
    end

    task automatic add(input string name, input int op, input logic [31:0] adr,
                       input logic [31:0] dat, input logic [31:0] exp);
        t_name[n_tests] = name;
        t_op[n_tests]   = op;
        t_adr[n_tests]  = adr;
        t_dat[n_tests]  = dat;
        t_exp[n_tests]  = exp;
        n_tests++;
    endtask

    task automatic wb_access(input logic we, input wb_adr_t adr, input wb_dat_t dat);
        @(posedge sysclk_i);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= dat;
        do @(posedge sysclk_i); while (!wb_ack);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic send_cmd(input cmd_word_t word, input logic locked);
        @(posedge sysclk_i);
        command        <= word;
        command_valid  <= 1'b1;
        command_locked <= locked;
        @(posedge sysclk_i);
        command_valid  <= 1'b0;
        command_locked <= 1'b1;
    endtask

    task automatic load_table();
        n_tests = 0;
        add("dis_wr", OP_WR, 12'h804, 32'h55, 0);
        add("dis_rd", OP_RD, 12'h804, 0, 32'h55);
        add("slot7_rd", OP_RD, 12'h1C0, 0, 0);
        add("dis_set", OP_WR, 12'h804, 32'h08, 0);
        add("q_run", OP_WR, 12'h808, RUN_START, 0);
        add("q_trig", OP_WR, 12'h80C, 32'h1234, 0);
        add("q_fw", OP_WR, 12'h810, 32'h1A5, 0);
        add("stat_pend", OP_RD, 12'h814, 0, 32'h7);
        add("unlocked", OP_CMD, 0, 32'hA000_0000, 0);
        add("stat_held", OP_RD, 12'h814, 0, 32'h7);
        add("splice_all", OP_CMD, 1, 32'hB800_0000, 32'hAD2C_91A5);
        add("stat_clr", OP_RD, 12'h814, 0, 32'h100);
        add("trig1", OP_WR, 12'h80C, 32'h42, 0);
        add("trig1_cmd", OP_CMD, 1, 32'hA500_0000, 32'hA500_0214);
        add("drain1", OP_STALL, 0, 20, 0);
        add("ev0_rd", OP_RD, 12'h000, 0, 1);
        add("hold2", OP_STALL, 32'h04, 2, 0);
        add("trig2", OP_WR, 12'h80C, 32'h100, 0);
        add("trig2_cmd", OP_CMD, 1, 32'hA000_0000, 32'hA000_0804);
        add("drain2", OP_STALL, 32'h04, 20, 0);
        add("trig3", OP_WR, 12'h80C, 32'h101, 0);
        add("trig3_cmd", OP_CMD, 1, 32'hA000_0000, 32'hA000_080C);
        add("release", OP_STALL, 0, 20, 0);
        add("drop2_rd", OP_RD, 12'h084, 0, 1);
        add("frames2_rd", OP_RD, 12'h088, 0, 2);
        add("frames0_rd", OP_RD, 12'h008, 0, 3);
        add("ev3_rd", OP_RD, 12'h0C0, 0, 3);
        add("ctl_reset", OP_WR, 12'h800, 1, 0);
        add("ev0_ctl", OP_RD, 12'h000, 0, 0);
        add("frames0_ctl", OP_RD, 12'h008, 0, 0);
        add("trig4", OP_WR, 12'h80C, 32'h7, 0);
        add("trig4_cmd", OP_CMD, 1, 32'hA000_0000, 32'hA000_003C);
        add("drain4", OP_STALL, 0, 20, 0);
        add("ev1_rd", OP_RD, 12'h040, 0, 1);
        add("q_reset", OP_WR, 12'h808, RUN_RESET, 0);
        add("reset_cmd", OP_CMD, 1, 32'hA000_0000, 32'hA000_0003);
        add("ev1_rst", OP_RD, 12'h040, 0, 0);
        add("frames1_rst", OP_RD, 12'h048, 0, 0);
        add("q_stop", OP_WR, 12'h808, RUN_STOP, 0);
        add("stop_cmd", OP_CMD, 1, 32'hA000_0000, 32'hA000_0002);
        add("trig5", OP_WR, 12'h80C, 32'h5, 0);
        add("trig5_cmd", OP_CMD, 1, 32'hA000_0000, 32'hA000_002C);
        add("drain5", OP_STALL, 0, 20, 0);
        add("ev0_stop", OP_RD, 12'h000, 0, 0);
        add("fw_plain", OP_WR, 12'h810, 32'h033, 0);
        add("fw_plain_cmd", OP_CMD, 1, 32'hA000_1230, 32'hA19C_1230);
        add("fw_marked", OP_WR, 12'h810, 32'h3C4, 0);
        add("fw_marked_cmd", OP_CMD, 1, 32'hA000_0000, 32'hBE24_0000);
        add("stat_marks", OP_RD, 12'h814, 0, 32'h200);
    endtask

    initial begin
        sysclk_i       = 1'b0;
        rst_i          = 1'b1;
        wb_cyc         = 1'b0;
        wb_stb         = 1'b0;
        wb_we          = 1'b0;
        wb_adr         = '0;
        wb_dat_w       = '0;
        command        = '0;
        command_valid  = 1'b0;
        command_locked = 1'b1;
        tready         = '0;
        hold           = '0;
        lfsr           = 16'd41;
        cycles         = 0;
        load_table();
        limit = n_tests * CYCLES_PER_TEST + 200;
        repeat (3) @(posedge sysclk_i);
        rst_i <= 1'b0;
        for (int t = 0; t < n_tests; t++) begin
            chk.begin_test(t_name[t]);
            case (t_op[t])
                OP_WR: wb_access(1'b1, t_adr[t][11:0], t_dat[t]);
                OP_RD: begin
                    chk.expect_read(t_exp[t]);
                    wb_access(1'b0, t_adr[t][11:0], '0);
                end
                OP_CMD: begin
                    if (t_adr[t][0]) begin
                        chk.expect_splice(t_exp[t]);
                        send_cmd(t_dat[t], 1'b1);
                        do @(posedge sysclk_i); while (!spliced_valid);
                    end else begin
                        // nothing may come out while unlocked
                        send_cmd(t_dat[t], 1'b0);
                        repeat (3) @(posedge sysclk_i);
                    end
                end
                default: begin
                    hold <= t_adr[t][NUM_SURF-1:0];
                    repeat (t_dat[t]) @(posedge sysclk_i);
                end
            endcase
            @(negedge sysclk_i);
            chk.end_test();
        end
        chk.summary();
        if (chk.errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
common/turfio_bus_pkg.sv
common/turfio_cmd_pkg.sv
common/wb_if.sv
hdl/wb_fanout.sv
hdl/surfturf_regs.sv
cmd_splice/turfio_cmd_splice.sv
surf/surf_channel.sv
hdl/surfturf_top.sv
verif/surfturf_checker.sv
verif/tb_surfturf.sv
